//--- Bender.yml
package:
  name: busCpu

sources:
  - files:
      - cpuPkg.sv
      - controlIf.sv
      - registerFile.sv
      - alu.sv
      - controlSequencer.sv
      - memCredit.sv
      - datapath.sv
      - cpuTop.sv
  - target: simulation
    files:
      - tbMemory.sv
      - cpuTb.sv

//--- alu.sv
`timescale 1ns/1ns

module alu import cpuPkg::*; (
	input logic [DataWidth-1:0] a,
	input logic [DataWidth-1:0] b,
	input aluOpT op,
	input logic [CondWidth-1:0] condition,
	output logic [DataWidth-1:0] result,
	output logic conditionMet
);

	logic [ShiftWidth-1:0] shiftAmount;

	assign shiftAmount = b[ShiftWidth-1:0];

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluShl: result = a << shiftAmount;
			aluShr: result = a >> shiftAmount;    // logical
			aluNeg: result = -b;
			aluNot: result = ~b;
			aluIncrement: result = a + 1'b1;
			default: result = b;
		endcase
	end

	// branch test on the value on b
	always_comb begin
		case (condition)
			CondZero: conditionMet = (b == '0);
			CondNonZero: conditionMet = (b != '0);
			CondPositive: conditionMet = !b[DataWidth-1];   // sign bit clear
			CondNegative: conditionMet = b[DataWidth-1];
			default: conditionMet = 1'b0;
		endcase
	end

endmodule

//--- controlIf.sv
`timescale 1ns/1ns

interface controlIf import cpuPkg::*; ();

	busSourceT busSource;
	aluOpT aluOp;
	regSelectT regSelect;
	logic regWrite;
	logic baseZero;       // r0 reads as zero
	logic loadY;
	logic loadZ;
	logic loadMar;
	logic loadMdr;
	logic loadIr;
	logic loadPc;
	logic loadPcIfCon;
	logic loadCon;
	logic mdrFromMemory;  // mdr input from memory, not bus
	opcodeT opcode;

	modport sequencer (output busSource, aluOp, regSelect, regWrite, baseZero, loadY, loadZ,
		loadMar, loadMdr, loadIr, loadPc, loadPcIfCon, loadCon, mdrFromMemory,
		input opcode);

	modport datapath (input busSource, aluOp, regSelect, regWrite, baseZero, loadY, loadZ,
		loadMar, loadMdr, loadIr, loadPc, loadPcIfCon, loadCon, mdrFromMemory,
		output opcode);

endinterface

//--- controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer import cpuPkg::*; (
	input logic Clock,
	input logic Reset,
	controlIf.sequencer ctrl,
	input logic canIssue,
	input logic memRspValid,
	output logic issue,
	output logic issueWrite,
	output logic halted
);

	stateT state;
	stateT nextState;
	aluOpT opAlu;
	logic usesImmediate;
	logic isUnary;
	logic isMemOp;

	always_comb begin
		case (ctrl.opcode)
			opAdd, opAddi, opLdi, opLd, opSt: opAlu = aluAdd;
			opSub: opAlu = aluSub;
			opAnd, opAndi: opAlu = aluAnd;
			opOr, opOri: opAlu = aluOr;
			opShl: opAlu = aluShl;
			opShr: opAlu = aluShr;
			opNeg: opAlu = aluNeg;
			opNot: opAlu = aluNot;
			default: opAlu = aluPass;
		endcase
	end

	assign usesImmediate = ctrl.opcode inside {opAddi, opAndi, opOri, opLdi, opLd, opSt};
	assign isUnary = ctrl.opcode inside {opNeg, opNot};
	assign isMemOp = ctrl.opcode inside {opLd, opSt};
	assign halted = (state == stHalted);

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			state <= stFetch0;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;    // memory states hold by default
		ctrl.busSource = busRegister;
		ctrl.aluOp = aluPass;
		ctrl.regSelect = selRa;
		ctrl.regWrite = 1'b0;
		ctrl.baseZero = 1'b0;
		ctrl.loadY = 1'b0;
		ctrl.loadZ = 1'b0;
		ctrl.loadMar = 1'b0;
		ctrl.loadMdr = 1'b0;
		ctrl.loadIr = 1'b0;
		ctrl.loadPc = 1'b0;
		ctrl.loadPcIfCon = 1'b0;
		ctrl.loadCon = 1'b0;
		ctrl.mdrFromMemory = 1'b0;
		issue = 1'b0;
		issueWrite = 1'b0;
		case (state)
			stFetch0: begin
				ctrl.busSource = busPc;
				ctrl.loadMar = 1'b1;
				ctrl.aluOp = aluIncrement;
				ctrl.loadZ = 1'b1;    // z = pc + 1
				nextState = stFetch1;
			end
			stFetch1: begin
				ctrl.busSource = busZLow;
				if (canIssue) begin
					ctrl.loadPc = 1'b1;
					issue = 1'b1;
					nextState = stFetch2;
				end
			end
			stFetch2: begin
				if (memRspValid) begin
					ctrl.mdrFromMemory = 1'b1;
					ctrl.loadMdr = 1'b1;
					nextState = stDecode;
				end
			end
			stDecode: begin
				ctrl.busSource = busMdr;
				ctrl.loadIr = 1'b1;   // opcode is bypassed from the bus this cycle
				case (ctrl.opcode)
					opAdd, opSub, opAnd, opOr, opShl, opShr,
					opAddi, opAndi, opOri, opLdi, opLd, opSt: nextState = stLoadY;
					opNeg, opNot: nextState = stCompute;
					opBr: nextState = stBranchCond;
					opHalt: nextState = stHalted;
					default: nextState = stFetch0;   // nop and unused codes
				endcase
			end
			stLoadY: begin
				ctrl.regSelect = selRb;
				ctrl.baseZero = ctrl.opcode inside {opLd, opLdi, opSt};
				ctrl.loadY = 1'b1;
				nextState = stCompute;
			end
			stCompute: begin
				ctrl.aluOp = opAlu;
				ctrl.loadZ = 1'b1;
				if (usesImmediate)
					ctrl.busSource = busImmediate;
				else
					ctrl.regSelect = isUnary ? selRb : selRc;
				nextState = isMemOp ? stLoadMar : stWriteBack;
			end
			stWriteBack: begin
				ctrl.busSource = busZLow;
				ctrl.regWrite = 1'b1;
				nextState = stFetch0;
			end
			stLoadMar: begin
				ctrl.busSource = busZLow;
				ctrl.loadMar = 1'b1;  // effective address
				nextState = (ctrl.opcode == opSt) ? stStoreData : stMemRead;
			end
			stMemRead: begin
				if (canIssue) begin
					issue = 1'b1;
					nextState = stMemWait;
				end
			end
			stMemWait: begin
				if (memRspValid) begin
					ctrl.mdrFromMemory = 1'b1;
					ctrl.loadMdr = 1'b1;
					nextState = stLoadResult;
				end
			end
			stLoadResult: begin
				ctrl.busSource = busMdr;
				ctrl.regWrite = 1'b1;
				nextState = stFetch0;
			end
			stStoreData: begin
				ctrl.loadMdr = 1'b1;  // ra onto the bus into mdr
				nextState = stMemWrite;
			end
			stMemWrite: begin
				if (canIssue) begin
					issue = 1'b1;
					issueWrite = 1'b1;
					nextState = stFetch0;   // no response to wait for
				end
			end
			stBranchCond: begin
				ctrl.loadCon = 1'b1;
				nextState = stBranchY;
			end
			stBranchY: begin
				ctrl.busSource = busPc;
				ctrl.loadY = 1'b1;
				nextState = stBranchZ;
			end
			stBranchZ: begin
				ctrl.busSource = busImmediate;
				ctrl.aluOp = aluAdd;
				ctrl.loadZ = 1'b1;
				nextState = stBranchPc;
			end
			stBranchPc: begin
				ctrl.busSource = busZLow;
				ctrl.loadPcIfCon = 1'b1;
				nextState = stFetch0;
			end
			stHalted: nextState = stHalted;   // until reset
			default: nextState = stFetch0;
		endcase
	end

endmodule

//--- cpuPkg.sv
package cpuPkg;

	localparam int DataWidth = 32;
	localparam int AddrWidth = 16;        // word address
	localparam int RegCount = 16;
	localparam int RegIndexWidth = 4;
	localparam int ShiftWidth = $clog2(DataWidth);

	// requests allowed in flight on the memory port
	localparam int MemCredits = 2;
	localparam int CreditWidth = $clog2(MemCredits + 1);

	// instruction fields
	localparam int OpcodeLsb = 27;
	localparam int OpcodeWidth = 5;
	localparam int RaLsb = 23;
	localparam int RbLsb = 19;
	localparam int RcLsb = 15;
	localparam int ImmWidth = 19;         // sign-extended C
	localparam int CondLsb = 19;
	localparam int CondWidth = 2;

	// branch conditions
	localparam logic [CondWidth-1:0] CondZero = 2'd0;
	localparam logic [CondWidth-1:0] CondNonZero = 2'd1;
	localparam logic [CondWidth-1:0] CondPositive = 2'd2;
	localparam logic [CondWidth-1:0] CondNegative = 2'd3;

	typedef enum logic [OpcodeWidth-1:0] {
		opLd = 5'd0, opLdi = 5'd1, opSt = 5'd2, opAdd = 5'd3, opSub = 5'd4,
		opShr = 5'd5, opShl = 5'd6, opAnd = 5'd9, opOr = 5'd10, opAddi = 5'd11,
		opAndi = 5'd12, opOri = 5'd13, opNeg = 5'd16, opNot = 5'd17, opBr = 5'd18,
		opNop = 5'd25, opHalt = 5'd26
	} opcodeT;

	typedef enum logic [4:0] {
		stFetch0, stFetch1, stFetch2, stDecode, stLoadY, stCompute, stWriteBack,
		stLoadMar, stMemRead, stMemWait, stLoadResult, stStoreData, stMemWrite,
		stBranchCond, stBranchY, stBranchZ, stBranchPc, stHalted
	} stateT;

	typedef enum logic [3:0] {
		aluPass, aluAdd, aluSub, aluAnd, aluOr, aluShl, aluShr, aluNeg, aluNot, aluIncrement
	} aluOpT;

	typedef enum logic [2:0] {busRegister, busPc, busZLow, busMdr, busImmediate} busSourceT;

	typedef enum logic [1:0] {selRa, selRb, selRc} regSelectT;

endpackage

//--- cpuTb.sv
`timescale 1ns/1ns

module cpuTb import cpuPkg::*; ();

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 8;
	localparam int unsigned Seed = 32'h30ad_b3ad;
	localparam int RandomCount = 60;
	localparam int MaxLatency = 5;
	localparam int LongestInstr = 9;
	localparam int DataBase = 'h100;      // data region above the program
	localparam int MemWords = 1 << AddrWidth;

	typedef struct packed {
		logic write;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
	} requestT;

	logic Clock;
	logic Reset;
	logic memReqValid;
	logic memReqWrite;
	logic [AddrWidth-1:0] memReqAddr;
	logic [DataWidth-1:0] memReqData;
	logic memCreditReturn;
	logic memRspValid;
	logic [DataWidth-1:0] memRspData;
	logic halted;
	logic [2:0] latency;

	logic [DataWidth-1:0] code [$];
	logic [DataWidth-1:0] modelMem [0:MemWords-1];
	requestT expected [$];      // fetches, loads and stores in issue order
	int instrCount = 0;
	int cycleLimit = 0;
	int cycleCount = 0;
	int outstanding = 0;
	int requestCount = 0;
	int errorCount = 0;

	cpuTop i_dut (
		.Clock(Clock),
		.Reset(Reset),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memCreditReturn(memCreditReturn),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.halted(halted)
	);

	tbMemory memory (
		.Clock(Clock),
		.Reset(Reset),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.latency(latency),
		.memCreditReturn(memCreditReturn),
		.memRspValid(memRspValid),
		.memRspData(memRspData)
	);

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	task automatic failRun(input string reason);
		$display("Simulation failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkValue(input string name, input logic [DataWidth-1:0] actual,
			input logic [DataWidth-1:0] want);
		if (actual !== want) begin
			errorCount++;
			$display("ERR %s: got 0x%h expected 0x%h", name, actual, want);
			failRun("value mismatch");
		end
	endtask

	function automatic logic [DataWidth-1:0] fillWord(input logic [AddrWidth-1:0] addr);
		return {addr ^ 16'hc3a5, addr};
	endfunction

	function automatic logic [DataWidth-1:0] makeInstr(input opcodeT op, input logic [3:0] ra,
			input logic [3:0] rb, input logic [18:0] low);
		return {op, ra, rb, low};
	endfunction

	// branch reach stops at lastTarget so the final stores always run
	function automatic logic [DataWidth-1:0] randomInstr(input int index, input int lastTarget);
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [18:0] imm;
		logic [DataWidth-1:0] word;
		int reach;
		ra = 4'($urandom);
		rb = 4'($urandom);
		rc = 4'($urandom);
		imm = 19'($urandom);
		reach = lastTarget - index - 1;
		if (reach > 6)
			reach = 6;
		case ($urandom_range(15, 0))
			0: word = makeInstr(opLd, ra, 4'd0, 19'(DataBase + rc));    // r0 base
			1: word = makeInstr(opLdi, ra, rb, imm);
			2: word = makeInstr(opSt, ra, 4'd0, 19'(DataBase + rc));
			3: word = makeInstr(opAdd, ra, rb, {rc, 15'd0});
			4: word = makeInstr(opSub, ra, rb, {rc, 15'd0});
			5: word = makeInstr(opShr, ra, rb, {rc, 15'd0});
			6: word = makeInstr(opShl, ra, rb, {rc, 15'd0});
			7: word = makeInstr(opAnd, ra, rb, {rc, 15'd0});
			8: word = makeInstr(opOr, ra, rb, {rc, 15'd0});
			9: word = makeInstr(opAddi, ra, rb, imm);
			10: word = makeInstr(opAndi, ra, rb, imm);
			11: word = makeInstr(opOri, ra, rb, imm);
			12: word = makeInstr(opNeg, ra, rb, 19'd0);
			13: word = makeInstr(opNot, ra, rb, 19'd0);
			14: word = makeInstr(opBr, ra, rb, 19'($urandom_range(reach, reach > 0 ? 1 : 0)));
			default: word = makeInstr(opNop, ra, rb, imm);
		endcase
		return word;
	endfunction

	task automatic buildProgram();
		int storeStart;
		storeStart = RegCount + RandomCount;
		for (int r = 0; r < RegCount; r++)
			code.push_back(makeInstr(opLdi, 4'(r), 4'd0, 19'($urandom)));
		for (int i = RegCount; i < storeStart; i++)
			code.push_back(randomInstr(i, storeStart));
		for (int r = 0; r < RegCount; r++)
			code.push_back(makeInstr(opSt, 4'(r), 4'd0, 19'(DataBase + 'h40 + r)));
		code.push_back(makeInstr(opHalt, 4'd0, 4'd0, 19'd0));
	endtask

	task automatic expectRequest(input logic write, input logic [AddrWidth-1:0] addr,
			input logic [DataWidth-1:0] data);
		requestT req;
		req.write = write;
		req.addr = addr;
		req.data = data;
		expected.push_back(req);
	endtask

	// instruction set model stepping one instruction per pass
	task automatic runModel();
		logic [DataWidth-1:0] regs [0:RegCount-1];
		logic [DataWidth-1:0] pc;
		logic [DataWidth-1:0] ir;
		logic [DataWidth-1:0] imm;
		logic [DataWidth-1:0] base;
		logic [DataWidth-1:0] rbVal;
		logic [DataWidth-1:0] rcVal;
		logic [AddrWidth-1:0] addr;
		logic [3:0] ra;
		logic taken;
		logic running;
		for (int r = 0; r < RegCount; r++)
			regs[r] = '0;
		pc = '0;
		running = 1'b1;
		while (running) begin
			expectRequest(1'b0, pc[AddrWidth-1:0], '0);
			ir = modelMem[pc[AddrWidth-1:0]];
			pc = pc + 1;
			instrCount++;
			ra = ir[26:23];
			rbVal = regs[ir[22:19]];
			rcVal = regs[ir[18:15]];
			base = (ir[22:19] == 4'd0) ? '0 : rbVal;
			imm = {{13{ir[18]}}, ir[18:0]};
			addr = 16'(base + imm);
			case (ir[31:27])
				opLd: begin
					expectRequest(1'b0, addr, '0);
					regs[ra] = modelMem[addr];
				end
				opSt: begin
					expectRequest(1'b1, addr, regs[ra]);
					modelMem[addr] = regs[ra];
				end
				opLdi: regs[ra] = base + imm;
				opAdd: regs[ra] = rbVal + rcVal;
				opSub: regs[ra] = rbVal - rcVal;
				opShr: regs[ra] = rbVal >> rcVal[4:0];
				opShl: regs[ra] = rbVal << rcVal[4:0];
				opAnd: regs[ra] = rbVal & rcVal;
				opOr: regs[ra] = rbVal | rcVal;
				opAddi: regs[ra] = rbVal + imm;
				opAndi: regs[ra] = rbVal & imm;
				opOri: regs[ra] = rbVal | imm;
				opNeg: regs[ra] = -rbVal;
				opNot: regs[ra] = ~rbVal;
				opBr: begin
					case (ir[20:19])
						2'd0: taken = (regs[ra] == '0);
						2'd1: taken = (regs[ra] != '0);
						2'd2: taken = !regs[ra][31];    // sign bit only
						default: taken = regs[ra][31];
					endcase
					if (taken)
						pc = pc + imm;
				end
				opHalt: running = 1'b0;
				default: ;
			endcase
			if (instrCount > 10 * code.size())
				failRun("model never reached halt");
		end
	endtask

	task automatic driveLatency();
		forever begin
			@(posedge Clock);
			latency = 3'($urandom_range(MaxLatency, 0));   // for the next request
		end
	endtask

	initial begin : mainFlow
		Reset = 1'b1;
		latency = 3'd0;
		void'($urandom(Seed));
		buildProgram();
		for (int a = 0; a < MemWords; a++)
			modelMem[a] = fillWord(a[AddrWidth-1:0]);
		for (int i = 0; i < code.size(); i++)
			modelMem[i] = code[i];
		for (int a = 0; a < MemWords; a++)
			memory.words[a] = modelMem[a];
		runModel();
		// a credit may come back up to one more latency after its request
		cycleLimit = ResetCycles + instrCount * (LongestInstr + 3 * (2 * MaxLatency + 2)) + 100;
		fork
			driveLatency();
		join_none
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		Reset = 1'b0;
		checkValue("memReqValid", memReqValid, 1'b0);
		checkValue("halted", halted, 1'b0);
		while (!halted)
			@(negedge Clock);
		checkValue("requests left at halt", expected.size(), 0);
		repeat (3 * (MaxLatency + 2)) @(negedge Clock);   // no request may follow
		checkValue("outstanding", outstanding, 0);
		$display("%0d instructions, %0d requests checked", instrCount, requestCount);
		if (errorCount == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			failRun("errors were counted");
		end
	end

	// request fields hold from one rising edge to the next
	always @(negedge Clock) begin : requestMonitor
		requestT want;
		if (!Reset && memReqValid) begin
			requestCount++;
			outstanding++;
			if (outstanding > MemCredits) begin
				failRun("more requests outstanding than credits");
			end else if (halted) begin
				failRun("request issued after halt");
			end else if (expected.size() == 0) begin
				failRun("request beyond the end of the program");
			end else begin
				want = expected.pop_front();
				checkValue("memReqWrite", memReqWrite, want.write);
				checkValue("memReqAddr", memReqAddr, want.addr);
				if (want.write)
					checkValue("memReqData", memReqData, want.data);
			end
		end
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (!Reset && memCreditReturn)
			outstanding--;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
			failRun("run did not halt within the cycle limit");
	end

endmodule

//--- cpuTop.sv
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; (
	input logic Clock,
	input logic Reset,
	output logic memReqValid,
	output logic memReqWrite,
	output logic [AddrWidth-1:0] memReqAddr,
	output logic [DataWidth-1:0] memReqData,
	input logic memCreditReturn,
	input logic memRspValid,
	input logic [DataWidth-1:0] memRspData,
	output logic halted
);

	logic issue;
	logic issueWrite;
	logic canIssue;
	logic [AddrWidth-1:0] marAddr;
	logic [DataWidth-1:0] mdrData;

	controlIf ctrlBus ();

	controlSequencer sequencer (
		.Clock(Clock),
		.Reset(Reset),
		.ctrl(ctrlBus.sequencer),
		.canIssue(canIssue),
		.memRspValid(memRspValid),
		.issue(issue),
		.issueWrite(issueWrite),
		.halted(halted)
	);

	datapath dataPath (
		.Clock(Clock),
		.Reset(Reset),
		.ctrl(ctrlBus.datapath),
		.memRspData(memRspData),
		.marAddr(marAddr),
		.mdrData(mdrData)
	);

	memCredit credit (
		.Clock(Clock),
		.Reset(Reset),
		.issue(issue),
		.issueWrite(issueWrite),
		.addr(marAddr),
		.data(mdrData),
		.memCreditReturn(memCreditReturn),
		.canIssue(canIssue),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData)
	);

endmodule

//--- datapath.sv
`timescale 1ns/1ns

module datapath import cpuPkg::*; (
	input logic Clock,
	input logic Reset,
	controlIf.datapath ctrl,
	input logic [DataWidth-1:0] memRspData,
	output logic [AddrWidth-1:0] marAddr,
	output logic [DataWidth-1:0] mdrData
);

	logic [DataWidth-1:0] bus;
	logic [DataWidth-1:0] pc;
	logic [DataWidth-1:0] ir;
	logic [DataWidth-1:0] irNext;
	logic [DataWidth-1:0] y;
	logic [DataWidth-1:0] z;
	logic [DataWidth-1:0] mdr;
	logic [AddrWidth-1:0] mar;
	logic con;                          // condition flip-flop
	logic [DataWidth-1:0] immediate;
	logic [RegIndexWidth-1:0] regIndex;
	logic [DataWidth-1:0] regData;
	logic [DataWidth-1:0] aluA;
	logic [DataWidth-1:0] aluResult;
	logic conditionMet;

	// decode sees the opcode while ir is being loaded
	assign irNext = ctrl.loadIr ? bus : ir;
	assign ctrl.opcode = opcodeT'(irNext[OpcodeLsb +: OpcodeWidth]);
	assign immediate = {{(DataWidth - ImmWidth){ir[ImmWidth-1]}}, ir[ImmWidth-1:0]};

	always_comb begin
		case (ctrl.regSelect)
			selRb: regIndex = ir[RbLsb +: RegIndexWidth];
			selRc: regIndex = ir[RcLsb +: RegIndexWidth];
			default: regIndex = ir[RaLsb +: RegIndexWidth];
		endcase
	end

	always_comb begin
		case (ctrl.busSource)
			busPc: bus = pc;
			busZLow: bus = z;
			busMdr: bus = mdr;
			busImmediate: bus = immediate;
			default: bus = regData;
		endcase
	end

	registerFile regFile (
		.Clock(Clock),
		.Reset(Reset),
		.readIndex(regIndex),
		.writeIndex(regIndex),
		.write(ctrl.regWrite),
		.baseZero(ctrl.baseZero),
		.writeData(bus),
		.readData(regData)
	);

	assign aluA = (ctrl.aluOp == aluIncrement) ? bus : y;  // pc + 1 without y

	alu aluUnit (
		.a(aluA),
		.b(bus),
		.op(ctrl.aluOp),
		.condition(ir[CondLsb +: CondWidth]),
		.result(aluResult),
		.conditionMet(conditionMet)
	);

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			pc <= '0;
			con <= 1'b0;
		end else begin
			if (ctrl.loadPc || (ctrl.loadPcIfCon && con))
				pc <= bus;
			if (ctrl.loadCon)
				con <= conditionMet;
		end
	end

	always_ff @(posedge Clock) begin
		ir <= irNext;
		if (ctrl.loadY)
			y <= bus;
		if (ctrl.loadZ)
			z <= aluResult;
		if (ctrl.loadMar)
			mar <= bus[AddrWidth-1:0];
		if (ctrl.loadMdr)
			mdr <= ctrl.mdrFromMemory ? memRspData : bus;
	end

	assign marAddr = mar;
	assign mdrData = mdr;

endmodule

//--- memCredit.sv
`timescale 1ns/1ns

module memCredit import cpuPkg::*; (
	input logic Clock,
	input logic Reset,
	input logic issue,
	input logic issueWrite,
	input logic [AddrWidth-1:0] addr,
	input logic [DataWidth-1:0] data,
	input logic memCreditReturn,
	output logic canIssue,
	output logic memReqValid,
	output logic memReqWrite,
	output logic [AddrWidth-1:0] memReqAddr,
	output logic [DataWidth-1:0] memReqData
);

	logic [CreditWidth-1:0] credits;
	logic spend;

	assign canIssue = (credits != '0);
	assign spend = issue && canIssue;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			credits <= CreditWidth'(MemCredits);
			memReqValid <= 1'b0;
		end else begin
			memReqValid <= spend;     // one-cycle request pulse
			case ({spend, memCreditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;  // both or neither
			endcase
		end
	end

	// request fields, valid alongside memReqValid
	always_ff @(posedge Clock) begin
		if (spend) begin
			memReqWrite <= issueWrite;
			memReqAddr <= addr;
			memReqData <= data;
		end
	end

endmodule

//--- registerFile.sv
`timescale 1ns/1ns

module registerFile import cpuPkg::*; (
	input logic Clock,
	input logic Reset,
	input logic [RegIndexWidth-1:0] readIndex,
	input logic [RegIndexWidth-1:0] writeIndex,
	input logic write,
	input logic baseZero,
	input logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] readData
);

	logic [DataWidth-1:0] regs [RegCount];

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= '0;
		end else if (write) begin
			regs[writeIndex] <= writeData;
		end
	end

	// base addressing treats r0 as zero
	always_comb begin
		if (baseZero && readIndex == '0)
			readData = '0;
		else
			readData = regs[readIndex];
	end

endmodule

//--- sim.f
cpuPkg.sv
controlIf.sv
registerFile.sv
alu.sv
controlSequencer.sv
memCredit.sv
datapath.sv
cpuTop.sv
tbMemory.sv
cpuTb.sv

//--- tbMemory.sv
`timescale 1ns/1ns

module tbMemory import cpuPkg::*; (
	input logic Clock,
	input logic Reset,
	input logic memReqValid,
	input logic memReqWrite,
	input logic [AddrWidth-1:0] memReqAddr,
	input logic [DataWidth-1:0] memReqData,
	input logic [2:0] latency,
	output logic memCreditReturn,
	output logic memRspValid,
	output logic [DataWidth-1:0] memRspData
);

	typedef struct packed {
		logic write;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
		logic [31:0] due;           // cycle the request completes in
	} pendingT;

	logic [DataWidth-1:0] words [0:(1 << AddrWidth) - 1];
	pendingT pending [$];
	int creditDue [$];              // cycles the credits come back in
	int cycle = 0;

	initial begin
		memCreditReturn = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
	end

	// requests finish strictly in order, at most one per cycle
	always @(negedge Clock) begin : serve
		pendingT entry;
		memCreditReturn = 1'b0;
		memRspValid = 1'b0;
		cycle++;
		if (Reset) begin
			pending.delete();
			creditDue.delete();
		end else begin
			if (memReqValid) begin
				entry.write = memReqWrite;
				entry.addr = memReqAddr;
				entry.data = memReqData;
				entry.due = cycle + latency;
				pending.push_back(entry);
			end
			if (pending.size() > 0) begin
				entry = pending[0];
				if (entry.due <= cycle) begin
					entry = pending.pop_front();
					creditDue.push_back(cycle + latency);   // credit may lag the response
					if (entry.write) begin
						words[entry.addr] = entry.data;
					end else begin
						memRspValid = 1'b1;
						memRspData = words[entry.addr];
					end
				end
			end
			if (creditDue.size() > 0) begin
				if (creditDue[0] <= cycle) begin
					creditDue.delete(0);
					memCreditReturn = 1'b1;
				end
			end
		end
	end

endmodule
